// File: Makefile
# Verilator build of the standby I3C testbench

BIN  := obj_dir/Vtb_standby_i3c
SRCS := $(filter-out +%,$(shell cat all.f)) sim/tb_bus_driver.svh

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): all.f $(SRCS)
	verilator --binary --timing -f all.f --top-module tb_standby_i3c -o Vtb_standby_i3c

# Exit status of the simulator is the result of the run
run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// File: all.f
+incdir+sim
logic/i3c_pkg.sv
logic/bus_monitor.sv
logic/bus_rx_flow.sv
logic/target_fsm.sv
logic/descriptor_rx.sv
logic/standby_i3c.sv
sim/tb_standby_i3c.sv

// File: logic/bus_monitor.sv
// FilterCycles must be at least 1; the bus is assumed much slower than clk_i and no events leave while disabled
`timescale 1ns/1ns

module bus_monitor #(
  parameter int unsigned FilterCycles = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic enable_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_posedge_o,
  output logic scl_negedge_o,
  output logic sda_o,
  output logic start_det_o,
  output logic rstart_det_o,
  output logic stop_det_o
);

  localparam int unsigned CntWidth = $clog2(FilterCycles + 1);

  // Bit 0 carries SCL, bit 1 carries SDA
  logic [1:0] sync1_q;
  logic [1:0] sync2_q;
  logic [1:0] filt_q;
  logic [1:0] filt_d1_q;
  logic [CntWidth-1:0] cnt_q [2];
  logic xfer_open_q;

  logic scl_rise;
  logic scl_fall;
  logic scl_held_high;
  logic start_cond;
  logic stop_cond;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sync1_q   <= '1;
      sync2_q   <= '1;
      filt_q    <= '1;
      filt_d1_q <= '1;
      cnt_q     <= '{default: '0};
    end else begin
      sync1_q   <= {sda_i, scl_i};
      sync2_q   <= sync1_q;
      filt_d1_q <= filt_q;
      for (int i = 0; i < 2; i++) begin
        if (sync2_q[i] == filt_q[i]) begin
          cnt_q[i] <= '0;
        end else if (cnt_q[i] == CntWidth'(FilterCycles - 1)) begin
          filt_q[i] <= sync2_q[i];
          cnt_q[i]  <= '0;
        end else begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign scl_rise      = filt_q[0] & ~filt_d1_q[0];
  assign scl_fall      = ~filt_q[0] & filt_d1_q[0];
  assign scl_held_high = filt_q[0] & filt_d1_q[0];
  // SDA may only move with SCL high at START and STOP
  assign start_cond    = scl_held_high & ~filt_q[1] & filt_d1_q[1];
  assign stop_cond     = scl_held_high & filt_q[1] & ~filt_d1_q[1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_posedge_o <= 1'b0;
      scl_negedge_o <= 1'b0;
      start_det_o   <= 1'b0;
      rstart_det_o  <= 1'b0;
      stop_det_o    <= 1'b0;
      xfer_open_q   <= 1'b0;
    end else begin
      scl_posedge_o <= enable_i & scl_rise;
      scl_negedge_o <= enable_i & scl_fall;
      start_det_o   <= enable_i & start_cond & ~xfer_open_q;
      rstart_det_o  <= enable_i & start_cond & xfer_open_q;
      stop_det_o    <= enable_i & stop_cond;
      if (!enable_i || stop_cond) begin
        xfer_open_q <= 1'b0;
      end else if (start_cond) begin
        xfer_open_q <= 1'b1;
      end
    end
  end

  assign sda_o = filt_q[1];

endmodule

// File: logic/bus_rx_flow.sv
// Requests are single-cycle strobes; a new request restarts the shifter and rx_data is stale until rx_done
`timescale 1ns/1ns

module bus_rx_flow (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  scl_posedge_i,
  input  logic                  sda_i,
  input  logic                  start_det_i,
  input  logic                  stop_det_i,
  input  logic                  rx_req_bit_i,
  input  logic                  rx_req_byte_i,
  output logic                  rx_done_o,
  output i3c_pkg::hdr_byte_u    rx_data_o
);

  localparam int unsigned BitCntWidth = $clog2(i3c_pkg::ByteWidth + 1);

  logic                         active_q;
  logic [BitCntWidth-1:0]       bits_left_q;
  logic [i3c_pkg::ByteWidth-1:0] shift_q;
  logic                         sample;

  assign sample = active_q & scl_posedge_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      bits_left_q <= '0;
      rx_done_o   <= 1'b0;
    end else begin
      rx_done_o <= 1'b0;
      if (start_det_i || stop_det_i) begin
        active_q <= 1'b0;
      end else if (rx_req_byte_i) begin
        active_q    <= 1'b1;
        bits_left_q <= BitCntWidth'(i3c_pkg::ByteWidth);
      end else if (rx_req_bit_i) begin
        active_q    <= 1'b1;
        bits_left_q <= BitCntWidth'(1);
      end else if (sample) begin
        bits_left_q <= bits_left_q - 1'b1;
        if (bits_left_q == BitCntWidth'(1)) begin
          active_q  <= 1'b0;
          rx_done_o <= 1'b1;
        end
      end
    end
  end

  // MSB first, so a single bit ends up in bit 0
  always_ff @(posedge clk_i) begin
    if (sample) begin
      shift_q <= {shift_q[i3c_pkg::ByteWidth-2:0], sda_i};
    end
  end

  assign rx_data_o.raw = shift_q;

endmodule

// File: logic/descriptor_rx.sv
// CountWidth must not exceed 16; the descriptor queue is assumed never full and bytes are dropped when the RX queue is
`timescale 1ns/1ns

module descriptor_rx #(
  parameter int unsigned CountWidth = 16
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               byte_valid_i,
  input  logic               byte_perr_i,
  input  logic               xfer_end_i,
  input  logic               rx_queue_full_i,
  input  logic [7:0]         byte_data_i,
  input  i3c_pkg::hdr_byte_u xfer_hdr_i,
  output logic               rx_queue_wvalid_o,
  output logic               rx_desc_queue_wvalid_o,
  output logic [7:0]         rx_queue_wdata_o,
  output logic [31:0]        rx_desc_queue_wdata_o
);

  localparam int unsigned CountFieldWidth = i3c_pkg::DescCountMsb - i3c_pkg::DescCountLsb + 1;

  logic [CountWidth-1:0]         byte_cnt_q;
  logic                          perr_q;
  logic                          ovf_q;
  logic                          byte_accept;
  logic [i3c_pkg::DescWidth-1:0] desc;

  assign byte_accept = byte_valid_i & ~rx_queue_full_i;

  always_comb begin
    desc = '0;
    desc[i3c_pkg::DescCountMsb:i3c_pkg::DescCountLsb] = CountFieldWidth'(byte_cnt_q);
    desc[i3c_pkg::DescParityErrBit] = perr_q;
    desc[i3c_pkg::DescOverflowBit]  = ovf_q;
    desc[i3c_pkg::DescAddrMsb:i3c_pkg::DescAddrLsb] = xfer_hdr_i.raw;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_cnt_q             <= '0;
      perr_q                 <= 1'b0;
      ovf_q                  <= 1'b0;
      rx_queue_wvalid_o      <= 1'b0;
      rx_desc_queue_wvalid_o <= 1'b0;
    end else begin
      rx_queue_wvalid_o      <= byte_accept;
      rx_desc_queue_wvalid_o <= xfer_end_i;
      if (xfer_end_i) begin
        byte_cnt_q <= '0;
        perr_q     <= 1'b0;
        ovf_q      <= 1'b0;
      end else begin
        // Count only what reached the queue
        if (byte_accept) begin
          byte_cnt_q <= byte_cnt_q + 1'b1;
        end
        if (byte_valid_i && byte_perr_i) begin
          perr_q <= 1'b1;
        end
        if (byte_valid_i && rx_queue_full_i) begin
          ovf_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_accept) begin
      rx_queue_wdata_o <= byte_data_i;
    end
    if (xfer_end_i) begin
      rx_desc_queue_wdata_o <= desc;
    end
  end

endmodule

// File: logic/i3c_pkg.sv
// Field positions assume a 32-bit RX descriptor and 8-bit bus bytes; changing them breaks the TTI format
package i3c_pkg;

  // Width of one bus byte and of one RX queue entry
  parameter int unsigned ByteWidth = 8;

  // RX descriptor layout
  parameter int unsigned DescWidth = 32;
  parameter int unsigned DescCountLsb = 0;
  parameter int unsigned DescCountMsb = 15;
  parameter int unsigned DescParityErrBit = 16;
  parameter int unsigned DescOverflowBit = 17;
  parameter int unsigned DescAddrLsb = 24;
  parameter int unsigned DescAddrMsb = 31;

  // First byte after (r)START is read as address plus RnW, data bytes as raw
  typedef union packed {
    logic [ByteWidth-1:0] raw;
    struct packed {
      logic [6:0] addr;
      logic       rnw;
    } hdr;
  } hdr_byte_u;

endpackage

// File: logic/standby_i3c.sv
// Receive-only I3C target; SCL is never driven and SDA is pulled low only for the header ACK
`timescale 1ns/1ns

module standby_i3c #(
  parameter int unsigned FilterCycles = 2,
  parameter int unsigned CountWidth   = 16
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        i3c_standby_en_i,
  input  logic        ctrl_scl_i,
  input  logic        ctrl_sda_i,
  input  logic        rx_queue_full_i,
  input  logic        target_sta_addr_valid_i,
  input  logic        target_dyn_addr_valid_i,
  input  logic [6:0]  target_sta_addr_i,
  input  logic [6:0]  target_dyn_addr_i,
  output logic        ctrl_scl_o,
  output logic        ctrl_sda_o,
  output logic        rx_queue_wvalid_o,
  output logic        rx_desc_queue_wvalid_o,
  output logic        bus_start_o,
  output logic        bus_rstart_o,
  output logic        bus_stop_o,
  output logic        bus_addr_valid_o,
  output logic [7:0]  rx_queue_wdata_o,
  output logic [31:0] rx_desc_queue_wdata_o,
  output logic [7:0]  bus_addr_o
);

  logic               scl_posedge;
  logic               scl_negedge;
  logic               sda_filt;
  logic               bus_start_det;
  logic               bus_rstart_det;
  logic               bus_stop_det;
  logic               any_start_det;
  logic               rx_req_bit;
  logic               rx_req_byte;
  logic               rx_done;
  i3c_pkg::hdr_byte_u rx_data;
  logic               byte_valid;
  logic               byte_perr;
  logic [7:0]         byte_data;
  logic               xfer_end;
  i3c_pkg::hdr_byte_u xfer_hdr;

  assign ctrl_scl_o = 1'b1;

  // Repeated START also aborts a pending receive
  assign any_start_det = bus_start_det | bus_rstart_det;

  bus_monitor #(
    .FilterCycles(FilterCycles)
  ) u_bus_monitor (
    .clk_i,
    .rst_ni,
    .enable_i     (i3c_standby_en_i),
    .scl_i        (ctrl_scl_i),
    .sda_i        (ctrl_sda_i),
    .scl_posedge_o(scl_posedge),
    .scl_negedge_o(scl_negedge),
    .sda_o        (sda_filt),
    .start_det_o  (bus_start_det),
    .rstart_det_o (bus_rstart_det),
    .stop_det_o   (bus_stop_det)
  );

  bus_rx_flow u_bus_rx_flow (
    .clk_i,
    .rst_ni,
    .scl_posedge_i(scl_posedge),
    .sda_i        (sda_filt),
    .start_det_i  (any_start_det),
    .stop_det_i   (bus_stop_det),
    .rx_req_bit_i (rx_req_bit),
    .rx_req_byte_i(rx_req_byte),
    .rx_done_o    (rx_done),
    .rx_data_o    (rx_data)
  );

  target_fsm u_target_fsm (
    .clk_i,
    .rst_ni,
    .enable_i               (i3c_standby_en_i),
    .scl_negedge_i          (scl_negedge),
    .start_det_i            (bus_start_det),
    .rstart_det_i           (bus_rstart_det),
    .stop_det_i             (bus_stop_det),
    .rx_done_i              (rx_done),
    .rx_data_i              (rx_data),
    .target_sta_addr_i,
    .target_dyn_addr_i,
    .target_sta_addr_valid_i,
    .target_dyn_addr_valid_i,
    .rx_req_bit_o           (rx_req_bit),
    .rx_req_byte_o          (rx_req_byte),
    .sda_o                  (ctrl_sda_o),
    .bus_addr_valid_o,
    .byte_valid_o           (byte_valid),
    .byte_perr_o            (byte_perr),
    .xfer_end_o             (xfer_end),
    .bus_addr_o,
    .xfer_hdr_o             (xfer_hdr),
    .byte_data_o            (byte_data)
  );

  descriptor_rx #(
    .CountWidth(CountWidth)
  ) u_descriptor_rx (
    .clk_i,
    .rst_ni,
    .byte_valid_i          (byte_valid),
    .byte_perr_i           (byte_perr),
    .xfer_end_i            (xfer_end),
    .rx_queue_full_i,
    .byte_data_i           (byte_data),
    .xfer_hdr_i            (xfer_hdr),
    .rx_queue_wvalid_o,
    .rx_desc_queue_wvalid_o,
    .rx_queue_wdata_o,
    .rx_desc_queue_wdata_o
  );

  assign bus_start_o  = bus_start_det;
  assign bus_rstart_o = bus_rstart_det;
  assign bus_stop_o   = bus_stop_det;

endmodule

// File: logic/target_fsm.sv
// Private writes only; a matching read header is NACKed since this target cannot transmit
`timescale 1ns/1ns

module target_fsm (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               enable_i,
  input  logic               scl_negedge_i,
  input  logic               start_det_i,
  input  logic               rstart_det_i,
  input  logic               stop_det_i,
  input  logic               rx_done_i,
  input  i3c_pkg::hdr_byte_u rx_data_i,
  input  logic [6:0]         target_sta_addr_i,
  input  logic [6:0]         target_dyn_addr_i,
  input  logic               target_sta_addr_valid_i,
  input  logic               target_dyn_addr_valid_i,
  output logic               rx_req_bit_o,
  output logic               rx_req_byte_o,
  output logic               sda_o,
  output logic               bus_addr_valid_o,
  output logic               byte_valid_o,
  output logic               byte_perr_o,
  output logic               xfer_end_o,
  output i3c_pkg::hdr_byte_u bus_addr_o,
  output i3c_pkg::hdr_byte_u xfer_hdr_o,
  output logic [7:0]         byte_data_o
);

  localparam logic [2:0] StIdle     = 3'd0;
  localparam logic [2:0] StHeader   = 3'd1;
  localparam logic [2:0] StAck      = 3'd2;
  localparam logic [2:0] StData     = 3'd3;
  localparam logic [2:0] StTbit     = 3'd4;
  localparam logic [2:0] StWaitStop = 3'd5;

  logic [2:0] state_q;
  logic       xfer_active_q;

  logic [6:0] own_addr;
  logic       own_addr_valid;
  logic       write_match;
  logic       hdr_done;
  logic       data_done;
  logic       tbit_done;
  logic       tbit_bad;
  logic       bus_event;

  // Dynamic address wins once assigned
  assign own_addr       = target_dyn_addr_valid_i ? target_dyn_addr_i : target_sta_addr_i;
  assign own_addr_valid = target_dyn_addr_valid_i | target_sta_addr_valid_i;
  assign write_match    = own_addr_valid & (rx_data_i.hdr.addr == own_addr) &
                          ~rx_data_i.hdr.rnw;

  assign hdr_done  = (state_q == StHeader) & rx_done_i;
  assign data_done = (state_q == StData) & rx_done_i;
  assign tbit_done = (state_q == StTbit) & rx_done_i;
  assign bus_event = start_det_i | rstart_det_i | stop_det_i;

  // Odd parity over data byte plus T bit
  assign tbit_bad = ~^{byte_data_o, rx_data_i.raw[0]};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= StIdle;
      xfer_active_q    <= 1'b0;
      sda_o            <= 1'b1;
      rx_req_bit_o     <= 1'b0;
      rx_req_byte_o    <= 1'b0;
      bus_addr_valid_o <= 1'b0;
      byte_valid_o     <= 1'b0;
      byte_perr_o      <= 1'b0;
      xfer_end_o       <= 1'b0;
    end else begin
      rx_req_bit_o     <= 1'b0;
      rx_req_byte_o    <= 1'b0;
      bus_addr_valid_o <= 1'b0;
      byte_valid_o     <= 1'b0;
      byte_perr_o      <= 1'b0;
      xfer_end_o       <= 1'b0;
      if (!enable_i) begin
        state_q       <= StIdle;
        xfer_active_q <= 1'b0;
        sda_o         <= 1'b1;
      end else if (bus_event) begin
        // Any bus condition closes the running transfer
        xfer_end_o    <= xfer_active_q;
        xfer_active_q <= 1'b0;
        sda_o         <= 1'b1;
        if (stop_det_i) begin
          state_q <= StIdle;
        end else begin
          state_q       <= StHeader;
          rx_req_byte_o <= 1'b1;
        end
      end else begin
        case (state_q)
          StHeader: begin
            if (hdr_done) begin
              bus_addr_valid_o <= 1'b1;
              if (write_match) begin
                state_q       <= StAck;
                xfer_active_q <= 1'b1;
              end else begin
                state_q <= StWaitStop;
              end
            end
          end
          StAck: begin
            // Pull low on the first SCL fall, let go on the second
            if (scl_negedge_i) begin
              if (sda_o) begin
                sda_o <= 1'b0;
              end else begin
                sda_o         <= 1'b1;
                rx_req_byte_o <= 1'b1;
                state_q       <= StData;
              end
            end
          end
          StData: begin
            if (data_done) begin
              rx_req_bit_o <= 1'b1;
              state_q      <= StTbit;
            end
          end
          StTbit: begin
            if (tbit_done) begin
              byte_valid_o  <= 1'b1;
              byte_perr_o   <= tbit_bad;
              rx_req_byte_o <= 1'b1;
              state_q       <= StData;
            end
          end
          StIdle, StWaitStop: begin
            state_q <= state_q;
          end
          default: begin
            state_q <= StIdle;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (hdr_done) begin
      bus_addr_o <= rx_data_i;
    end
    if (hdr_done && write_match) begin
      xfer_hdr_o <= rx_data_i;
    end
    if (data_done) begin
      byte_data_o <= rx_data_i.raw;
    end
  end

endmodule

// File: sim/tb_bus_driver.svh
// Controller tasks for a bus far slower than clk; SDA only changes while SCL is low, except at START and STOP
localparam int HalfPeriod = 8;
localparam int HoldCycles = 2;

task automatic wait_clocks(input int n);
  repeat (n) @(posedge clk);
endtask

// Short hold after the SCL fall before SDA moves
task automatic send_bit(input logic b);
  wait_clocks(HoldCycles);
  sda_drv <= b;
  wait_clocks(HalfPeriod - HoldCycles);
  scl_drv <= 1'b1;
  wait_clocks(HalfPeriod);
  scl_drv <= 1'b0;
endtask

// From an idle bus
task automatic send_start();
  wait_clocks(HalfPeriod);
  sda_drv <= 1'b0;
  wait_clocks(HalfPeriod);
  scl_drv <= 1'b0;
endtask

// Entered with SCL low, leaves SCL low
task automatic send_rstart();
  wait_clocks(HoldCycles);
  sda_drv <= 1'b1;
  wait_clocks(HalfPeriod - HoldCycles);
  scl_drv <= 1'b1;
  wait_clocks(HalfPeriod);
  sda_drv <= 1'b0;
  wait_clocks(HalfPeriod);
  scl_drv <= 1'b0;
endtask

// Leaves both lines high
task automatic send_stop();
  wait_clocks(HoldCycles);
  sda_drv <= 1'b0;
  wait_clocks(HalfPeriod - HoldCycles);
  scl_drv <= 1'b1;
  wait_clocks(HalfPeriod);
  sda_drv <= 1'b1;
  wait_clocks(HalfPeriod);
endtask

// Header MSB first, then the ACK slot with SDA released
task automatic send_header(input logic [7:0] hdr, output logic acked);
  for (int i = 7; i >= 0; i--) begin
    send_bit(hdr[i]);
  end
  wait_clocks(HoldCycles);
  sda_drv <= 1'b1;
  wait_clocks(HalfPeriod - HoldCycles);
  scl_drv <= 1'b1;
  // Target ACK is SDA pulled low at the SCL rise
  acked = ~sda_line;
  wait_clocks(HalfPeriod);
  scl_drv <= 1'b0;
endtask

// Data byte MSB first, followed by its T bit
task automatic send_data_byte(input logic [7:0] data, input logic tbit);
  for (int i = 7; i >= 0; i--) begin
    send_bit(data[i]);
  end
  send_bit(tbit);
endtask

// File: sim/tb_standby_i3c.sv
// Directed tests with default parameters; the first failed check or timeout ends the run
`timescale 1ns/1ns

module tb_standby_i3c;

  localparam int WaitLimit = 400;
  localparam int EvDesc = 0;
  localparam int EvAddr = 1;
  localparam int EvStop = 2;
  localparam logic [6:0] StaAddr = 7'h2a;
  localparam logic [6:0] DynAddr = 7'h35;

  logic        clk;
  logic        rst_n;
  logic        scl_drv;
  logic        sda_drv;
  logic        scl_line;
  logic        sda_line;
  logic        rx_full;
  logic        sta_valid;
  logic        dyn_valid;
  logic        scl_out;
  logic        sda_out;
  logic        rx_wvalid;
  logic        desc_wvalid;
  logic        start_p;
  logic        rstart_p;
  logic        stop_p;
  logic        addr_valid;
  logic [7:0]  rx_wdata;
  logic [31:0] desc_wdata;
  logic [7:0]  bus_addr;

  // Collected by the monitor and read relative to the bases below
  logic [7:0]  rx_bytes [$];
  logic [31:0] desc_words [$];
  logic [7:0]  addr_seen [$];
  int          start_cnt;
  int          rstart_cnt;
  int          stop_cnt;

  logic [7:0]  tx_bytes [$];
  int          rx_base;
  int          desc_base;
  int          addr_base;
  int          start_base;
  int          rstart_base;
  int          stop_base;

  // Open-drain bus
  assign scl_line = scl_drv & scl_out;
  assign sda_line = sda_drv & sda_out;

  standby_i3c UUT (
    .clk_i                  (clk),
    .rst_ni                 (rst_n),
    .i3c_standby_en_i       (1'b1),
    .ctrl_scl_i             (scl_line),
    .ctrl_sda_i             (sda_line),
    .rx_queue_full_i        (rx_full),
    .target_sta_addr_valid_i(sta_valid),
    .target_dyn_addr_valid_i(dyn_valid),
    .target_sta_addr_i      (StaAddr),
    .target_dyn_addr_i      (DynAddr),
    .ctrl_scl_o             (scl_out),
    .ctrl_sda_o             (sda_out),
    .rx_queue_wvalid_o      (rx_wvalid),
    .rx_desc_queue_wvalid_o (desc_wvalid),
    .bus_start_o            (start_p),
    .bus_rstart_o           (rstart_p),
    .bus_stop_o             (stop_p),
    .bus_addr_valid_o       (addr_valid),
    .rx_queue_wdata_o       (rx_wdata),
    .rx_desc_queue_wdata_o  (desc_wdata),
    .bus_addr_o             (bus_addr)
  );

  `include "tb_bus_driver.svh"

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rx_wvalid) begin
      rx_bytes.push_back(rx_wdata);
    end
    if (desc_wvalid) begin
      desc_words.push_back(desc_wdata);
    end
    if (addr_valid) begin
      addr_seen.push_back(bus_addr);
    end
    if (start_p) begin
      start_cnt++;
    end
    if (rstart_p) begin
      rstart_cnt++;
    end
    if (stop_p) begin
      stop_cnt++;
    end
  end

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected byte %h, got %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_desc(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected descriptor %h, got %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_hdr(input string name, input i3c_pkg::hdr_byte_u exp,
                           input i3c_pkg::hdr_byte_u act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected addr %h rnw %b, got addr %h rnw %b", name,
               exp.hdr.addr, exp.hdr.rnw, act.hdr.addr, act.hdr.rnw);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %b, got %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[FAIL] %s: expected count %0d, got %0d", name, exp, act);
      abort_run();
    end
  endtask

  function automatic int events_seen(input int kind);
    case (kind)
      EvDesc:  return desc_words.size();
      EvAddr:  return addr_seen.size();
      default: return stop_cnt;
    endcase
  endfunction

  task automatic wait_events(input int kind, input int target, input string name,
                             input string what);
    int cycles;
    cycles = 0;
    while (events_seen(kind) < target && cycles < WaitLimit) begin
      @(posedge clk);
      cycles++;
    end
    if (events_seen(kind) < target) begin
      $display("%s: timed out waiting for the %s", name, what);
      abort_run();
    end
  endtask

  // T bit makes the count of ones over byte and T odd
  function automatic logic parity_tbit(input logic [7:0] data);
    return ~(^data);
  endfunction

  // Header on top, then six zero bits, overflow, parity error and a 16-bit count
  function automatic logic [31:0] expected_desc(input int count, input logic perr,
                                                input logic ovf, input logic [6:0] addr);
    return {addr, 1'b0, 6'b0, ovf, perr, 16'(count)};
  endfunction

  // Lines released and no strobes once out of reset
  task automatic check_reset_outputs();
    check_bit("reset ctrl_scl_o", 1'b1, scl_out);
    check_bit("reset ctrl_sda_o", 1'b1, sda_out);
    check_bit("reset rx_queue_wvalid_o", 1'b0, rx_wvalid);
    check_bit("reset rx_desc_queue_wvalid_o", 1'b0, desc_wvalid);
    check_bit("reset bus_start_o", 1'b0, start_p);
    check_bit("reset bus_rstart_o", 1'b0, rstart_p);
    check_bit("reset bus_stop_o", 1'b0, stop_p);
    check_bit("reset bus_addr_valid_o", 1'b0, addr_valid);
  endtask

  task automatic set_address_valid(input logic sta_v, input logic dyn_v);
    wait_clocks(1);
    sta_valid <= sta_v;
    dyn_valid <= dyn_v;
  endtask

  task automatic fill_payload(input int n);
    tx_bytes.delete();
    for (int i = 0; i < n; i++) begin
      tx_bytes.push_back(8'($urandom));
    end
  endtask

  task automatic mark_bases();
    rx_base     = rx_bytes.size();
    desc_base   = desc_words.size();
    addr_base   = addr_seen.size();
    start_base  = start_cnt;
    rstart_base = rstart_cnt;
    stop_base   = stop_cnt;
  endtask

  // RX queue reads full for payload bytes full_lo up to full_hi - 1
  task automatic write_transfer(input string name, input logic [6:0] addr, input int bad_t,
                                input int full_lo, input int full_hi, input logic exp_ack,
                                input logic end_rstart);
    i3c_pkg::hdr_byte_u hdr;
    logic acked;
    hdr.hdr.addr = addr;
    hdr.hdr.rnw  = 1'b0;
    send_start();
    send_header(hdr.raw, acked);
    check_bit(name, exp_ack, acked);
    for (int i = 0; i < tx_bytes.size(); i++) begin
      rx_full <= (i >= full_lo) && (i < full_hi);
      send_data_byte(tx_bytes[i], parity_tbit(tx_bytes[i]) ^ (i == bad_t));
    end
    rx_full <= 1'b0;
    if (end_rstart) begin
      send_rstart();
    end else begin
      send_stop();
    end
  endtask

  task automatic check_transfer(input string name, input logic [6:0] addr, input int full_lo,
                                input int full_hi, input logic perr);
    int kept;
    int k;
    kept = 0;
    for (int i = 0; i < tx_bytes.size(); i++) begin
      if (i < full_lo || i >= full_hi) begin
        kept++;
      end
    end
    wait_events(EvStop, stop_base + 1, name, "STOP strobe");
    wait_events(EvDesc, desc_base + 1, name, "RX descriptor write");
    // A second descriptor would show up within these cycles
    wait_clocks(10);
    check_count(name, 1, desc_words.size() - desc_base);
    check_count(name, kept, rx_bytes.size() - rx_base);
    k = rx_base;
    for (int i = 0; i < tx_bytes.size(); i++) begin
      if (i < full_lo || i >= full_hi) begin
        check_byte(name, tx_bytes[i], rx_bytes[k]);
        k++;
      end
    end
    check_desc(name, expected_desc(kept, perr, kept != tx_bytes.size(), addr),
               desc_words[desc_base]);
  endtask

  task automatic check_addr_seen(input string name, input int idx, input logic [6:0] addr,
                                 input logic rnw);
    i3c_pkg::hdr_byte_u exp_hdr;
    i3c_pkg::hdr_byte_u act_hdr;
    wait_events(EvAddr, addr_base + idx + 1, name, "address strobe");
    exp_hdr.hdr.addr = addr;
    exp_hdr.hdr.rnw  = rnw;
    act_hdr.raw      = addr_seen[addr_base + idx];
    check_hdr(name, exp_hdr, act_hdr);
  endtask

  task automatic test_static_write();
    set_address_valid(1'b1, 1'b0);
    fill_payload(5);
    mark_bases();
    write_transfer("static_write", StaAddr, -1, 0, 0, 1'b1, 1'b0);
    check_transfer("static_write", StaAddr, 0, 0, 1'b0);
    check_count("static_write start", 1, start_cnt - start_base);
    check_count("static_write stop", 1, stop_cnt - stop_base);
  endtask

  task automatic test_addr_choice();
    set_address_valid(1'b1, 1'b1);
    tx_bytes.delete();
    mark_bases();
    write_transfer("addr_choice sta", StaAddr, -1, 0, 0, 1'b0, 1'b0);
    check_addr_seen("addr_choice sta", 0, StaAddr, 1'b0);
    wait_events(EvStop, stop_base + 1, "addr_choice sta", "STOP strobe");
    wait_clocks(10);
    check_count("addr_choice sta rx", 0, rx_bytes.size() - rx_base);
    check_count("addr_choice sta desc", 0, desc_words.size() - desc_base);
    fill_payload(3);
    mark_bases();
    write_transfer("addr_choice dyn", DynAddr, -1, 0, 0, 1'b1, 1'b0);
    check_transfer("addr_choice dyn", DynAddr, 0, 0, 1'b0);
  endtask

  task automatic test_parity_error();
    fill_payload(4);
    mark_bases();
    write_transfer("parity_error", DynAddr, 2, 0, 0, 1'b1, 1'b0);
    check_transfer("parity_error", DynAddr, 0, 0, 1'b1);
  endtask

  task automatic test_overflow();
    fill_payload(6);
    mark_bases();
    write_transfer("overflow", DynAddr, -1, 2, 4, 1'b1, 1'b0);
    check_transfer("overflow", DynAddr, 2, 4, 1'b0);
  endtask

  task automatic test_rstart_read();
    i3c_pkg::hdr_byte_u hdr;
    logic acked;
    fill_payload(2);
    mark_bases();
    write_transfer("rstart_read", DynAddr, -1, 0, 0, 1'b1, 1'b1);
    hdr.hdr.addr = DynAddr;
    hdr.hdr.rnw  = 1'b1;
    send_header(hdr.raw, acked);
    check_bit("rstart_read ack", 1'b0, acked);
    check_addr_seen("rstart_read", 1, DynAddr, 1'b1);
    send_stop();
    check_transfer("rstart_read", DynAddr, 0, 0, 1'b0);
    check_count("rstart_read rstart", 1, rstart_cnt - rstart_base);
  endtask

  initial begin
    void'($urandom(32'heba28874));
    rst_n     <= 1'b0;
    scl_drv   <= 1'b1;
    sda_drv   <= 1'b1;
    rx_full   <= 1'b0;
    sta_valid <= 1'b0;
    dyn_valid <= 1'b0;
    wait_clocks(4);
    rst_n <= 1'b1;
    wait_clocks(4);
    check_reset_outputs();
    test_static_write();
    test_addr_choice();
    test_parity_error();
    test_overflow();
    test_rstart_read();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
